// File: all.f
common/backend_pkg.sv
idu/decoder.sv
iru/rename_table.sv
isu/issue_stage.sv
isu/phys_regfile.sv
isu/reorder_buffer.sv
exu/int_alu.sv
src/backend.sv
tb/tb_backend.sv

// File: common/backend_pkg.sv
package backend_pkg;

    localparam int XLEN      = 64;
    localparam int LREG_NUM  = 32;
    localparam int PREG_NUM  = 48;   // p0 is hardwired zero
    localparam int PREG_W    = $clog2(PREG_NUM);
    localparam int ROB_DEPTH = 8;
    localparam int ROB_W     = $clog2(ROB_DEPTH);
    localparam int FREE_NUM  = PREG_NUM - LREG_NUM;
    localparam int FREE_W    = $clog2(FREE_NUM);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [XLEN-1:0]              xlen_t;
    typedef logic [XLEN-1:0]              pc_t;
    typedef logic [31:0]                  instr_t;
    typedef logic [$clog2(LREG_NUM)-1:0] lreg_t;
    typedef logic [PREG_W-1:0]            preg_t;
    typedef logic [ROB_W-1:0]             robid_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_packet_t;

    typedef struct packed {
        pc_t     pc;
        lreg_t   lrs1;
        lreg_t   lrs2;
        lreg_t   lrd;
        xlen_t   imm;
        logic    src2_is_imm;
        logic    need_to_wb;
        alu_op_t alu_op;
    } decoded_uop_t;

    typedef struct packed {
        decoded_uop_t dec;
        preg_t        prs1;
        preg_t        prs2;
        preg_t        prd;
        preg_t        old_prd;
        robid_t       robid;
    } renamed_uop_t;

    typedef struct packed {
        robid_t  robid;
        preg_t   prd;
        logic    need_to_wb;
        alu_op_t alu_op;
        xlen_t   src1;
        xlen_t   src2;
    } issue_uop_t;

    typedef struct packed {
        logic   valid;
        robid_t robid;
        preg_t  prd;
        logic   need_to_wb;
        xlen_t  result;
    } writeback_t;

    typedef struct packed {
        pc_t   pc;
        lreg_t lrd;
        logic  need_to_wb;
        preg_t old_prd;
        xlen_t result;
    } commit_t;

endpackage

// File: exu/int_alu.sv
`timescale 1ns/1ps
module int_alu
    import backend_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       iss_valid,
    input  issue_uop_t iss_uop,
    output writeback_t wb
);
    xlen_t      src1;
    xlen_t      src2;
    logic [5:0] shamt;
    xlen_t      result;

    assign src1  = iss_uop.src1;
    assign src2  = iss_uop.src2;
    assign shamt = src2[5:0];   // rv64 shift amount

    always_comb begin
        case (iss_uop.alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SLT:  result = xlen_t'($signed(src1) < $signed(src2));
            ALU_SLTU: result = xlen_t'(src1 < src2);
            ALU_XOR:  result = src1 ^ src2;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $signed(src1) >>> shamt;
            ALU_OR:   result = src1 | src2;
            default:  result = src1 & src2;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= iss_valid;
            if (iss_valid) begin
                wb.robid      <= iss_uop.robid;
                wb.prd        <= iss_uop.prd;
                wb.need_to_wb <= iss_uop.need_to_wb;
                wb.result     <= result;
            end
        end
    end

endmodule

// File: idu/decoder.sv
`timescale 1ns/1ps
module decoder
    import backend_pkg::*;
(
    input  logic          clock,
    input  logic          rst,
    input  logic          ibuffer_valid,
    input  fetch_packet_t ibuffer_packet,
    output logic          ibuffer_ready,
    output logic          dec_valid,
    output decoded_uop_t  dec_uop,
    input  logic          dec_ready
);
    instr_t       instr;
    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         shift_ok;
    logic         is_op;
    logic         is_op_imm;
    alu_op_t      alu_op;
    decoded_uop_t uop_d;

    assign instr  = ibuffer_packet.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign is_op = (opcode == OPC_OP) && (funct7 == 7'b0000000 ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign is_op_imm = (opcode == OPC_OP_IMM) && shift_ok;

    always_comb begin
        case (funct3)
            3'b001:  shift_ok = instr[31:26] == 6'b000000;   // slli
            3'b101:  shift_ok = instr[31:26] == 6'b000000 || instr[31:26] == 6'b010000;
            default: shift_ok = 1'b1;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && instr[30]) ? ALU_SUB : ALU_ADD;   // no subi
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    // anything else leaves as a nop reading x0
    always_comb begin
        uop_d        = '0;
        uop_d.pc     = ibuffer_packet.pc;
        uop_d.alu_op = alu_op;
        if (is_op || is_op_imm) begin
            uop_d.lrs1        = instr[19:15];
            uop_d.lrs2        = is_op ? instr[24:20] : '0;
            uop_d.lrd         = instr[11:7];
            uop_d.imm         = {{(XLEN-12){instr[31]}}, instr[31:20]};
            uop_d.src2_is_imm = is_op_imm;
            uop_d.need_to_wb  = instr[11:7] != '0;   // x0 never written
        end
    end

    assign ibuffer_ready = !dec_valid || dec_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (ibuffer_ready) begin
            dec_valid <= ibuffer_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (ibuffer_valid && ibuffer_ready) begin
            dec_uop <= uop_d;
        end
    end

endmodule

// File: iru/rename_table.sv
`timescale 1ns/1ps
module rename_table
    import backend_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  logic         dec_valid,
    input  decoded_uop_t dec_uop,
    output logic         dec_ready,
    output logic         alloc_valid,
    input  logic         alloc_ready,
    input  robid_t       alloc_robid,
    output logic         ren_valid,
    output renamed_uop_t ren_uop,
    input  logic         ren_ready,
    input  logic         commit_valid,
    input  commit_t      commit_info
);
    preg_t             map_table [LREG_NUM];
    preg_t             free_list [FREE_NUM];
    logic [FREE_W-1:0] free_head;
    logic [FREE_W-1:0] free_tail;
    logic [FREE_W:0]   free_cnt;   // 0..FREE_NUM
    logic              fire;
    logic              pop;
    logic              push;

    assign dec_ready   = (!ren_valid || ren_ready) && alloc_ready &&
                         (free_cnt != '0 || !dec_uop.need_to_wb);
    assign fire        = dec_valid && dec_ready;
    assign alloc_valid = fire;
    assign pop         = fire && dec_uop.need_to_wb;
    assign push        = commit_valid && commit_info.need_to_wb;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < LREG_NUM; i++) begin
                map_table[i] <= preg_t'(i);
            end
            for (int i = 0; i < FREE_NUM; i++) begin
                free_list[i] <= preg_t'(LREG_NUM + i);
            end
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= (FREE_W+1)'(FREE_NUM);
        end else begin
            if (pop) begin
                map_table[dec_uop.lrd] <= free_list[free_head];
                free_head              <= free_head + 1'b1;
            end
            if (push) begin
                free_list[free_tail] <= commit_info.old_prd;
                free_tail            <= free_tail + 1'b1;
            end
            free_cnt <= free_cnt + (FREE_W+1)'(push) - (FREE_W+1)'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ren_valid <= 1'b0;
        end else if (!ren_valid || ren_ready) begin
            ren_valid <= fire;
        end
    end

    // sources see the map before this uop's own update
    always_ff @(posedge clock) begin
        if (fire) begin
            ren_uop.dec     <= dec_uop;
            ren_uop.prs1    <= map_table[dec_uop.lrs1];
            ren_uop.prs2    <= map_table[dec_uop.lrs2];
            ren_uop.prd     <= dec_uop.need_to_wb ? free_list[free_head] : '0;
            ren_uop.old_prd <= dec_uop.need_to_wb ? map_table[dec_uop.lrd] : '0;
            ren_uop.robid   <= alloc_robid;
        end
    end

endmodule

// File: isu/issue_stage.sv
`timescale 1ns/1ps
module issue_stage
    import backend_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  logic         ren_valid,
    input  renamed_uop_t ren_uop,
    output logic         ren_ready,
    output preg_t        rd_addr1,
    output preg_t        rd_addr2,
    input  xlen_t        rd_data1,
    input  xlen_t        rd_data2,
    output logic         iss_valid,
    output issue_uop_t   iss_uop,
    input  writeback_t   wb
);
    logic [PREG_NUM-1:0] busy;
    logic                slot_valid;
    renamed_uop_t        slot_uop;
    logic                src_ready;

    assign src_ready = !busy[slot_uop.prs1] && !busy[slot_uop.prs2];
    assign iss_valid = slot_valid && src_ready;
    assign ren_ready = !slot_valid || iss_valid;

    assign rd_addr1 = slot_uop.prs1;
    assign rd_addr2 = slot_uop.prs2;

    always_comb begin
        iss_uop.robid      = slot_uop.robid;
        iss_uop.prd        = slot_uop.prd;
        iss_uop.need_to_wb = slot_uop.dec.need_to_wb;
        iss_uop.alu_op     = slot_uop.dec.alu_op;
        iss_uop.src1       = rd_data1;
        iss_uop.src2       = slot_uop.dec.src2_is_imm ? slot_uop.dec.imm : rd_data2;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else if (ren_ready) begin
            slot_valid <= ren_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (ren_valid && ren_ready) begin
            slot_uop <= ren_uop;
        end
    end

    // p0 is never allocated so it never turns busy
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb.valid && wb.need_to_wb) begin
                busy[wb.prd] <= 1'b0;
            end
            if (ren_valid && ren_ready && ren_uop.dec.need_to_wb) begin
                busy[ren_uop.prd] <= 1'b1;
            end
        end
    end

endmodule

// File: isu/phys_regfile.sv
`timescale 1ns/1ps
module phys_regfile
    import backend_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  preg_t      rd_addr1,
    input  preg_t      rd_addr2,
    input  writeback_t wb,
    output xlen_t      rd_data1,
    output xlen_t      rd_data2
);
    xlen_t regs [PREG_NUM];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.need_to_wb) begin
            regs[wb.prd] <= wb.result;
        end
    end

    // readers issue the cycle after writeback so no bypass
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

// File: isu/reorder_buffer.sv
`timescale 1ns/1ps
module reorder_buffer
    import backend_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  logic         alloc_valid,
    output logic         alloc_ready,
    output robid_t       alloc_robid,
    input  renamed_uop_t ren_uop,
    input  writeback_t   wb,
    output logic         commit_valid,
    output commit_t      commit_info
);
    commit_t              rob_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] rob_done;
    logic [ROB_W:0]       head;   // msb is the wrap bit
    logic [ROB_W:0]       tail;
    robid_t               head_idx;
    robid_t               tail_idx;
    logic                 empty;
    logic                 full;
    logic                 alloc_fire;
    logic                 fill_pending;

    assign head_idx   = head[ROB_W-1:0];
    assign tail_idx   = tail[ROB_W-1:0];
    assign empty      = head == tail;
    assign full       = head_idx == tail_idx && head[ROB_W] != tail[ROB_W];
    assign alloc_fire = alloc_valid && alloc_ready;

    assign alloc_ready  = !full;
    assign alloc_robid  = tail_idx;
    assign commit_valid = !empty && rob_done[head_idx];
    assign commit_info  = rob_mem[head_idx];

    always_ff @(posedge clock) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            rob_done     <= '0;
            fill_pending <= 1'b0;
        end else begin
            fill_pending <= alloc_fire;
            if (alloc_fire) begin
                tail               <= tail + 1'b1;
                rob_done[tail_idx] <= 1'b0;
            end
            if (wb.valid) begin
                rob_done[wb.robid] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;   // retire head
            end
        end
    end

    // ren_uop holds the newly allocated uop one cycle after allocation
    always_ff @(posedge clock) begin
        if (fill_pending) begin
            rob_mem[ren_uop.robid].pc         <= ren_uop.dec.pc;
            rob_mem[ren_uop.robid].lrd        <= ren_uop.dec.lrd;
            rob_mem[ren_uop.robid].need_to_wb <= ren_uop.dec.need_to_wb;
            rob_mem[ren_uop.robid].old_prd    <= ren_uop.old_prd;
        end
        if (wb.valid) begin
            rob_mem[wb.robid].result <= wb.result;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build with verilator and run, status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_backend -f all.f -o sim_tb_backend &&
./obj_dir/sim_tb_backend | tee /dev/stderr | grep -q "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: src/backend.sv
`timescale 1ns/1ps
module backend
    import backend_pkg::*;
(
    input  logic          clock,
    input  logic          rst,
    input  logic          ibuffer_valid,
    input  fetch_packet_t ibuffer_packet,
    output logic          ibuffer_ready,
    output logic          commit_valid,
    output commit_t       commit_info
);
    logic         dec_valid;
    logic         dec_ready;
    decoded_uop_t dec_uop;
    logic         alloc_valid;
    logic         alloc_ready;
    robid_t       alloc_robid;
    logic         ren_valid;
    logic         ren_ready;
    renamed_uop_t ren_uop;
    preg_t        rd_addr1;
    preg_t        rd_addr2;
    xlen_t        rd_data1;
    xlen_t        rd_data2;
    logic         iss_valid;
    issue_uop_t   iss_uop;
    writeback_t   wb;

    decoder u_decoder (
        .clock         (clock),
        .rst           (rst),
        .ibuffer_valid (ibuffer_valid),
        .ibuffer_packet(ibuffer_packet),
        .ibuffer_ready (ibuffer_ready),
        .dec_valid     (dec_valid),
        .dec_uop       (dec_uop),
        .dec_ready     (dec_ready)
    );

    rename_table u_rename_table (
        .clock       (clock),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_uop     (dec_uop),
        .dec_ready   (dec_ready),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_robid (alloc_robid),
        .ren_valid   (ren_valid),
        .ren_uop     (ren_uop),
        .ren_ready   (ren_ready),
        .commit_valid(commit_valid),     // frees old_prd
        .commit_info (commit_info)
    );

    issue_stage u_issue_stage (
        .clock    (clock),
        .rst      (rst),
        .ren_valid(ren_valid),
        .ren_uop  (ren_uop),
        .ren_ready(ren_ready),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .iss_valid(iss_valid),
        .iss_uop  (iss_uop),
        .wb       (wb)
    );

    phys_regfile u_phys_regfile (
        .clock   (clock),
        .rst     (rst),
        .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2),
        .wb      (wb),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2)
    );

    reorder_buffer u_reorder_buffer (
        .clock       (clock),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_robid (alloc_robid),
        .ren_uop     (ren_uop),
        .wb          (wb),
        .commit_valid(commit_valid),
        .commit_info (commit_info)
    );

    int_alu u_int_alu (
        .clock    (clock),
        .rst      (rst),
        .iss_valid(iss_valid),
        .iss_uop  (iss_uop),
        .wb       (wb)
    );

endmodule

// File: tb/tb_backend.sv
`timescale 1ns/1ps
module tb_backend
    import backend_pkg::*;
();
    localparam int NUM_INSTR      = 2000;
    localparam int STREAM_TIMEOUT = 40000;
    localparam int DRAIN_TIMEOUT  = 300;

    logic          clock;
    logic          rst;
    logic          ibuffer_valid;
    fetch_packet_t ibuffer_packet;
    logic          ibuffer_ready;
    logic          commit_valid;
    commit_t       commit_info;

    xlen_t   arch_regs [LREG_NUM];   // ISA model state
    preg_t   map_model [LREG_NUM];
    preg_t   free_model [$];         // in the order the free list hands them out
    commit_t exp_q [$];
    int      accepted;
    int      committed;
    logic    pending;                // packet offered but not yet taken
    pc_t     next_pc;

    backend i_backend (
        .clock         (clock),
        .rst           (rst),
        .ibuffer_valid (ibuffer_valid),
        .ibuffer_packet(ibuffer_packet),
        .ibuffer_ready (ibuffer_ready),
        .commit_valid  (commit_valid),
        .commit_info   (commit_info)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_lreg(string name, lreg_t got, lreg_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t %s got=%0d exp=%0d", $time, name, got, exp));
        end
    endtask

    task automatic check_preg(string name, preg_t got, preg_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t %s got=%0d exp=%0d", $time, name, got, exp));
        end
    endtask

    task automatic check_xlen(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [5:0]         sh;
        xlen_t              r;
        sa = a;
        sb = b;
        sh = b[5:0];   // rv64 shamt
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << sh;
            3'd2:    r = (sa < sb) ? 64'd1 : 64'd0;
            3'd3:    r = (a < b) ? 64'd1 : 64'd0;
            3'd4:    r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = sa >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // dense dependencies through x0..x7
    function automatic instr_t random_instr();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        logic [11:0] imm;
        instr_t      w;
        f3  = 3'($urandom_range(0, 7));
        rd  = 5'($urandom_range(0, 7));
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        if ($urandom_range(0, 9) == 0) begin
            w = $urandom;
            if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
                w[2] = ~w[2];   // force an unsupported opcode
            end
        end else if ($urandom_range(0, 1) == 0) begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            w  = {f7, rs2, rs1, f3, rd, OPC_OP};
        end else begin
            imm = 12'($urandom);
            if (f3 == 3'd1) begin
                imm = {6'b0, imm[5:0]};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, imm[10], 4'b0, imm[5:0]};   // srli or srai
            end
            w = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        return w;
    endfunction

    task automatic model_accept(fetch_packet_t pkt);
        instr_t     w;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        lreg_t      rd;
        xlen_t      a;
        xlen_t      b;
        logic       ok;
        logic       alt;
        commit_t    exp;
        w   = pkt.instr;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        a   = arch_regs[w[19:15]];
        b   = '0;
        ok  = 1'b0;
        alt = 1'b0;
        if (opc == OPC_OP) begin
            ok  = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            alt = f7[5];
            b   = arch_regs[w[24:20]];
        end else if (opc == OPC_OP_IMM) begin
            b = {{52{w[31]}}, w[31:20]};
            if (f3 == 3'd1) begin
                ok = w[31:26] == 6'h00;
            end else if (f3 == 3'd5) begin
                ok = w[31:26] == 6'h00 || w[31:26] == 6'h10;
            end else begin
                ok = 1'b1;
            end
            alt = f3 == 3'd5 && w[30];
        end
        exp            = '0;
        exp.pc         = pkt.pc;
        exp.need_to_wb = ok && rd != '0;
        if (exp.need_to_wb) begin
            exp.lrd       = rd;
            exp.result    = alu_ref(f3, alt, a, b);
            arch_regs[rd] = exp.result;
            exp.old_prd   = map_model[rd];
            map_model[rd] = free_model.pop_front();
            free_model.push_back(exp.old_prd);   // freed at commit, in program order
        end
        exp_q.push_back(exp);
    endtask

    task automatic drive_inputs(logic feed);
        if (!pending) begin
            if (feed && $urandom_range(0, 3) != 0) begin
                ibuffer_packet.pc    = next_pc;
                ibuffer_packet.instr = random_instr();
                ibuffer_valid        = 1'b1;
                pending              = 1'b1;
            end else begin
                ibuffer_valid = 1'b0;
            end
        end
    endtask

    // negedge view of what transfers on the next rising edge
    task automatic monitor();
        commit_t exp;
        if (commit_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("commit_valid went high with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                check_pc("commit_info.pc", commit_info.pc, exp.pc);
                check_bit("commit_info.need_to_wb", commit_info.need_to_wb, exp.need_to_wb);
                if (exp.need_to_wb) begin
                    check_lreg("commit_info.lrd", commit_info.lrd, exp.lrd);
                    check_xlen("commit_info.result", commit_info.result, exp.result);
                    check_preg("commit_info.old_prd", commit_info.old_prd, exp.old_prd);
                end
                committed++;
            end
        end
        if (ibuffer_valid && ibuffer_ready) begin
            model_accept(ibuffer_packet);
            accepted++;
            pending = 1'b0;
            next_pc = next_pc + 64'd4;
        end
        if (accepted - committed > ROB_DEPTH + 1) begin
            abort_run($sformatf("more than %0d instructions in flight", ROB_DEPTH + 1));
        end
    endtask

    task automatic run_cycle(logic feed);
        @(posedge clock);
        #1;
        drive_inputs(feed);
        @(negedge clock);
        monitor();
    endtask

    initial begin
        int cycles;
        void'($urandom(91));
        rst            = 1'b1;
        ibuffer_valid  = 1'b0;
        ibuffer_packet = '0;
        pending        = 1'b0;
        next_pc        = 64'h0000_0000_8000_0000;
        accepted       = 0;
        committed      = 0;
        for (int i = 0; i < LREG_NUM; i++) begin
            arch_regs[i] = '0;
            map_model[i] = preg_t'(i);
        end
        for (int i = LREG_NUM; i < PREG_NUM; i++) begin
            free_model.push_back(preg_t'(i));
        end
        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 10; i++) begin
            run_cycle(1'b0);
            check_bit("commit_valid", commit_valid, 1'b0);
            check_bit("ibuffer_ready", ibuffer_ready, 1'b1);
        end

        cycles = 0;
        while (accepted < NUM_INSTR) begin
            run_cycle(1'b1);
            cycles++;
            if (cycles > STREAM_TIMEOUT) begin
                abort_run("timeout while feeding the instruction stream");
            end
        end

        cycles = 0;
        while (exp_q.size() != 0) begin
            run_cycle(1'b0);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                abort_run("timeout waiting for the last instructions to commit");
            end
        end

        repeat (20) run_cycle(1'b0);   // any stray commit trips the monitor
        $display("=== PASS ===");
        $finish;
    end

endmodule
